/* design/pool_pkg.sv */
// shared types for the pooling reducer; window size fixed at 8, element width 8, no saturation
package pool_pkg;

  // ####################################################################
  // sizes
  // ####################################################################
  localparam int elem_w      = 8;
  localparam int win_size    = 8;   // power of two only
  localparam int tree_levels = 3;   // log2 of win_size
  localparam int cnt_w       = $clog2(win_size);
  localparam int fifo_depth  = 4;
  localparam int fifo_ptr_w  = $clog2(fifo_depth);

  // ####################################################################
  // types
  // ####################################################################
  typedef logic [elem_w-1:0] elem_t;  // one element or one result

  // bit 1 set picks max and clear picks min
  // bit 0 set makes the compare two's complement
  typedef logic [1:0] pool_op_t;

  typedef struct packed {
    elem_t    data;
    pool_op_t op;     // only the first beat of a window counts
    logic     last;   // must mark the eighth beat
  } pool_beat_t;

  typedef struct packed {
    pool_op_t                  op;
    elem_t [win_size-1:0]      elems;
  } pool_win_t;

  typedef struct packed {
    elem_t    value;
    pool_op_t op;
  } pool_res_t;

  typedef enum logic {
    filling,
    holding
  } loader_state_t;

endpackage

/* design/window_loader.sv */
// gathers eight beats into one window with the op of the first beat; the last bit is ignored here
`timescale 1ns/10ps

module window_loader
  import pool_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  pool_beat_t in_beat,
  input  logic       in_valid,
  output logic       in_ready,
  output pool_win_t  win,
  output logic       win_valid,
  input  logic       win_ready
);

  loader_state_t    state;
  logic [cnt_w-1:0] cnt;       // slot for the next beat
  logic             beat_acc;

  assign in_ready  = (state == filling);  // stalled while a full window waits
  assign win_valid = (state == holding);
  assign beat_acc  = in_valid & in_ready;

  // ####################################################################
  // control
  // ####################################################################
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= filling;
      cnt   <= '0;
    end else begin
      case (state)
        filling: begin
          if (beat_acc) begin
            cnt <= cnt + 1'b1;  // wraps to zero after the eighth beat
            if (cnt == cnt_w'(win_size - 1)) begin
              state <= holding;
            end
          end
        end
        holding: begin
          if (win_ready) state <= filling;  // tree took the window
        end
        default: state <= filling;
      endcase
    end
  end

  // window payload
  always_ff @(posedge clk) begin
    if (beat_acc) begin
      win.elems[cnt] <= in_beat.data;
      if (cnt == '0) begin
        win.op <= in_beat.op;  // op latched once per window
      end
    end
  end

endmodule

/* design/skid_buffer.sv */
// two-entry register stage; d_ready comes straight from a flop and q only changes on a transfer
`timescale 1ns/10ps

module skid_buffer
  import pool_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  pool_res_t d,
  input  logic      d_valid,
  output logic      d_ready,
  output pool_res_t q,
  output logic      q_valid,
  input  logic      q_ready
);

  pool_res_t main_q;
  pool_res_t skid_q;
  logic      main_valid;
  logic      skid_valid;
  logic      main_free;   // main register can take a new item this cycle

  assign d_ready   = ~skid_valid;
  assign q         = main_q;
  assign q_valid   = main_valid;
  assign main_free = ~main_valid | q_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_free) begin
        main_valid <= skid_valid | d_valid;
      end
      if (skid_valid) begin
        if (q_ready) skid_valid <= 1'b0;  // skid drains into main
      end else if (d_valid && !main_free) begin
        skid_valid <= 1'b1;               // park the incoming item on a stall
      end
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      main_q <= skid_valid ? skid_q : d;
    end
    if (!skid_valid && d_valid && !main_free) begin
      skid_q <= d;
    end
  end

endmodule

/* design/comparator_tree.sv */
// pipelined max/min reduction over one window; each level moves in lockstep at one cycle per level
`timescale 1ns/10ps

module comparator_tree
  import pool_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  pool_win_t win,
  input  logic      win_valid,
  output logic      win_ready,
  output pool_res_t res,
  output logic      res_valid,
  input  logic      res_ready
);

  // ####################################################################
  // per-level nodes where level 0 is the raw window
  // ####################################################################
  for (genvar lv = 0; lv <= tree_levels; lv++) begin : g_node
    pool_res_t data [2**(tree_levels-lv)];
    logic      valid;
    logic      ready;
    if (lv == 0) begin : g_in
      for (genvar e = 0; e < win_size; e++) begin : g_elem
        assign data[e] = '{value: win.elems[e], op: win.op};  // op rides with every element
      end
    end
  end

  for (genvar lv = 0; lv < tree_levels; lv++) begin : g_hs
    localparam int n = 2**(tree_levels - lv - 1);
    logic [n-1:0] buf_d_valid;
    logic [n-1:0] buf_d_ready;
    logic [n-1:0] buf_q_valid;
    logic [n-1:0] buf_q_ready;
  end

  // ####################################################################
  // comparators and their register stages
  // ####################################################################
  for (genvar lv = 0; lv < tree_levels; lv++) begin : g_level
    localparam int n = 2**(tree_levels - lv - 1);

    for (genvar c = 0; c < n; c++) begin : g_cmp
      pool_res_t left;
      pool_res_t right;
      pool_res_t result;
      logic      left_gt;

      assign left    = g_node[lv].data[2*c];
      assign right   = g_node[lv].data[2*c+1];
      assign left_gt = left.op[0] ? ($signed(left.value) > $signed(right.value))
                                  : (left.value > right.value);
      // max keeps left when greater and min keeps left when not greater
      assign result.value = (left.op[1] == left_gt) ? left.value : right.value;
      assign result.op    = left.op;

      skid_buffer u_skid (
        .clk     (clk),
        .arst_n  (arst_n),
        .d       (result),
        .d_valid (g_hs[lv].buf_d_valid[c]),
        .d_ready (g_hs[lv].buf_d_ready[c]),
        .q       (g_node[lv+1].data[c]),
        .q_valid (g_hs[lv].buf_q_valid[c]),
        .q_ready (g_hs[lv].buf_q_ready[c])
      );
    end

    // the level takes an item only when every buffer can
    assign g_node[lv].ready    = &g_hs[lv].buf_d_ready;
    assign g_hs[lv].buf_d_valid = {n{g_node[lv].valid & g_node[lv].ready}};

    // presented downstream only when every buffer holds its part
    assign g_node[lv+1].valid   = &g_hs[lv].buf_q_valid;
    assign g_hs[lv].buf_q_ready = {n{g_node[lv+1].valid & g_node[lv+1].ready}};
  end

  assign g_node[0].valid           = win_valid;
  assign win_ready                 = g_node[0].ready;
  assign res                       = g_node[tree_levels].data[0];
  assign res_valid                 = g_node[tree_levels].valid;
  assign g_node[tree_levels].ready = res_ready;

endmodule

/* design/result_fifo.sv */
// four-deep result queue; res_ready drops only when full and out_res holds until popped
`timescale 1ns/10ps

module result_fifo
  import pool_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  pool_res_t res,
  input  logic      res_valid,
  output logic      res_ready,
  output pool_res_t out_res,
  output logic      out_valid,
  input  logic      out_ready
);

  pool_res_t             mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;    // one extra bit so full is distinct from empty
  logic                  wr_en;
  logic                  rd_en;

  assign res_ready = (count != (fifo_ptr_w + 1)'(fifo_depth));
  assign out_valid = (count != '0);
  assign out_res   = mem[rd_ptr];  // head entry that only moves on a pop
  assign wr_en     = res_valid & res_ready;
  assign rd_en     = out_valid & out_ready;

  // ####################################################################
  // pointers and occupancy
  // ####################################################################
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= res;
    end
  end

endmodule

/* design/max_pool_top.sv */
// pooling reducer top with one window per eight input beats; results leave in window order
`timescale 1ns/10ps

module max_pool_top
  import pool_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  pool_beat_t in_beat,
  input  logic       in_valid,
  output logic       in_ready,
  output pool_res_t  out_res,
  output logic       out_valid,
  input  logic       out_ready
);

  pool_win_t win;
  logic      win_valid;
  logic      win_ready;
  pool_res_t res;
  logic      res_valid;
  logic      res_ready;

  // ####################################################################
  // input side, reduction, output queue
  // ####################################################################
  window_loader u_window_loader (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .win       (win),
    .win_valid (win_valid),
    .win_ready (win_ready)
  );

  comparator_tree u_comparator_tree (
    .clk       (clk),
    .arst_n    (arst_n),
    .win       (win),
    .win_valid (win_valid),
    .win_ready (win_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  result_fifo u_result_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .out_res   (out_res),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

/* tests/pool_assert.sv */
// handshake and framing checks bound into max_pool_top; assumes a window of win_size beats
`timescale 1ns/10ps

module pool_assert
  import pool_pkg::*;
(
  input logic       clk,
  input logic       arst_n,
  input pool_beat_t in_beat,
  input logic       in_valid,
  input logic       in_ready,
  input pool_res_t  out_res,
  input logic       out_valid,
  input logic       out_ready
);

  logic [cnt_w-1:0] beat_cnt;   // position of the next accepted beat
  logic [1:0]       since_rst;  // cycles since reset release up to 3

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_cnt  <= '0;
      since_rst <= '0;
    end else begin
      if (in_valid && in_ready) beat_cnt <= beat_cnt + 1'b1;
      if (since_rst != 2'd3) since_rst <= since_rst + 1'b1;
    end
  end

  in_hold: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_beat))
    else $error("in_beat changed while stalled");

  out_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_res))
    else $error("out_res changed while stalled");

  quiet_start: assert property (@(posedge clk) disable iff (!arst_n)
    since_rst != 2'd3 |-> !out_valid)
    else $error("out_valid too soon after reset");

  // last marks the eighth beat and nothing else
  last_frame: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid && in_ready |-> in_beat.last == (beat_cnt == cnt_w'(win_size - 1)))
    else $error("last bit out of place");

endmodule

bind max_pool_top pool_assert u_pool_assert (.*);

/* tests/pool_checker.sv */
// compares each output transfer of max_pool_top against expected results in window order
`timescale 1ns/10ps

module pool_checker
  import pool_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input pool_res_t out_res,
  input logic      out_valid,
  input logic      out_ready
);

  pool_res_t exp_q [$];     // one entry per window sent
  int        n_seen   = 0;
  int        n_errors = 0;

  task automatic add_expected(input pool_res_t r);
    exp_q.push_back(r);
  endtask

  // sampled on the edge where the transfer happens
  always @(posedge clk) begin
    pool_res_t exp_r;
    if (arst_n && out_valid && out_ready) begin
      n_seen++;
      if (exp_q.size() == 0) begin
        $display("result %h arrived with no window pending", out_res.value);
        n_errors++;
      end else begin
        exp_r = exp_q.pop_front();
        if (out_res.value !== exp_r.value) begin
          $display("FAIL out_res.value result %0d expected %h got %h",
                   n_seen, exp_r.value, out_res.value);
          n_errors++;
        end
        if (out_res.op !== exp_r.op) begin
          $display("FAIL out_res.op result %0d expected %h got %h",
                   n_seen, exp_r.op, out_res.op);
          n_errors++;
        end
      end
    end
  end

endmodule

/* tests/tb_max_pool.sv */
// testbench for max_pool_top; opens tests/pool_cases.txt so it must run from the project root
`timescale 1ns/10ps

module tb_max_pool
  import pool_pkg::*;
();

  localparam int in_timeout    = 1000;  // cycles to cover the long out_ready stall
  localparam int drain_timeout = 2000;

  logic        clk;
  logic        arst_n;
  pool_beat_t  in_beat;
  logic        in_valid;
  logic        in_ready;
  pool_res_t   out_res;
  logic        out_valid;
  logic        out_ready;
  logic [31:0] in_rng;
  logic [31:0] out_rng;
  int          tb_errors;
  int          n_win;
  int          cycle;
  logic        aborted;

  max_pool_top u_max_pool_top (.*);

  pool_checker u_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .out_res   (out_res),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // ####################################################################
  // clock, reset and consumer
  // ####################################################################
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    out_ready = 1'b0;
    out_rng   = lcg_next(32'h30ed_dbff);  // own stream apart from the input gaps
    cycle     = 0;
    forever begin
      @(posedge clk);
      #1;
      cycle++;
      out_rng = lcg_next(out_rng);
      if (cycle >= 60 && cycle < 180) begin
        out_ready = 1'b0;  // long stall that fills the fifo and backs up the tree
      end else begin
        out_ready = (out_rng[31:30] != 2'b00);
      end
    end
  end

  // one beat with an occasional idle cycle before it
  task automatic send_beat(input elem_t data, input pool_op_t op, input logic last);
    int   waited;
    logic ok;
    if (aborted) return;
    in_rng = lcg_next(in_rng);
    if (in_rng[31:29] == 3'b000) begin
      in_valid = 1'b0;
      @(posedge clk);
      #1;
    end
    in_beat  = '{data: data, op: op, last: last};
    in_valid = 1'b1;
    waited   = 0;
    ok       = 1'b0;
    while (!ok) begin
      @(negedge clk);
      ok = in_ready;  // settled value that the next rising edge sees
      @(posedge clk);
      #1;
      if (!ok) begin
        waited++;
        if (waited >= in_timeout) begin
          $display("timeout: in_ready stayed low for %0d cycles", in_timeout);
          tb_errors++;
          aborted  = 1'b1;
          in_valid = 1'b0;
          return;
        end
      end
    end
  endtask

  // ####################################################################
  // stimulus from the cases file
  // ####################################################################
  initial begin
    int       fd;
    int       waited;
    string    line;
    pool_op_t win_op;
    elem_t    e [win_size];
    elem_t    exp_v;
    arst_n    = 1'b0;
    in_beat   = '0;
    in_valid  = 1'b0;
    in_rng    = 32'h30ed_dbff;
    tb_errors = 0;
    n_win     = 0;
    aborted   = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    fd = $fopen("tests/pool_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/pool_cases.txt");
      tb_errors++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) == 0) break;
        if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", win_op, e[0], e[1], e[2], e[3],
                    e[4], e[5], e[6], e[7], exp_v) != 10) continue;  // comment or blank line
        u_checker.add_expected('{value: exp_v, op: win_op});
        // later beats carry the inverted op since only the first one may count
        for (int i = 0; i < win_size; i++) begin
          send_beat(e[i], (i == 0) ? win_op : ~win_op, i == win_size - 1);
        end
        n_win++;
      end
      $fclose(fd);
    end
    in_valid = 1'b0;
    if (n_win == 0) begin
      $display("no windows were read from the cases file");
      tb_errors++;
    end

    waited = 0;
    while (u_checker.n_seen < n_win && waited < drain_timeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (u_checker.n_seen < n_win) begin
      $display("timeout: only %0d of %0d results arrived", u_checker.n_seen, n_win);
      tb_errors++;
    end
    repeat (10) @(posedge clk);  // room for a stray extra result to show up
    #1;

    $display("errors: checker %0d, testbench %0d; results %0d of %0d",
             u_checker.n_errors, tb_errors, u_checker.n_seen, n_win);
    if (u_checker.n_errors == 0 && tb_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* tests/pool_cases.txt */
// columns: op e0 e1 e2 e3 e4 e5 e6 e7 expected, all hex
// op bit 1 picks max, bit 0 picks signed compare
2 ff 01 10 20 30 40 50 60 ff
2 03 7a 11 05 80 22 00 7f 80
0 ff 01 10 20 30 40 50 60 01
0 9c 44 c3 21 fe 88 37 5a 21
3 80 7f 00 ff 10 f0 01 81 7f
1 80 7f 00 ff 10 f0 01 81 80
3 ff fe 80 90 c0 a0 f1 e2 ff
1 01 02 7f 05 03 04 06 07 01
2 00 00 00 00 00 00 00 00 00
1 7f 7f 7f 7f 7f 7f 7f 7f 7f
0 00 ff 80 7f 01 fe 81 40 00
3 81 82 83 84 85 86 87 80 87

/* all.f */
design/pool_pkg.sv
design/window_loader.sv
design/skid_buffer.sv
design/comparator_tree.sv
design/result_fifo.sv
design/max_pool_top.sv
tests/pool_assert.sv
tests/pool_checker.sv
tests/tb_max_pool.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tb_max_pool
./obj_dir/Vtb_max_pool > sim.log 2>&1 || echo "simulation stopped with a nonzero status" >> sim.log
cat sim.log
if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
  exit 1
fi
